// ==== src/acc_params.svh ====
`ifndef ACC_PARAMS_SVH
`define ACC_PARAMS_SVH

`define DATA_W      8
`define BUS_TIMEOUT 12          // Cycles before an access is abandoned

// Opcodes
`define OP_ADD  5'b00000
`define OP_SUB  5'b00001
`define OP_OR   5'b00011
`define OP_AND  5'b00100
`define OP_SHFT 5'b00101
`define OP_LOAD 5'b01010
`define OP_STOR 5'b01011
`define OP_NOP  5'b01111

// Addressing flags
`define FL_DIR 3'b000
`define FL_IND 3'b001
`define FL_IMM 3'b010

// Shift flags
`define FL_LS0 3'b000
`define FL_LS1 3'b001
`define FL_RS0 3'b010
`define FL_RS1 3'b011

`endif

// ==== src/accPkg.sv ====
`include "acc_params.svh"

package accPkg;

	// Instruction word from stage 0
	typedef struct packed {
		logic [4:0]         opcode;
		logic [2:0]         flag;
		logic [`DATA_W-1:0] arg;
	} instrT;

	typedef enum logic [1:0] {
		modeDir,
		modeInd,
		modeImm
	} addrModeE;

	typedef enum logic [3:0] {
		exAdd,
		exSub,
		exOr,
		exAnd,
		exLoad,
		exStore,
		exShl0,
		exShl1,
		exShr0,
		exShr1
	} execOpE;

	// Command handed to the datapath
	typedef struct packed {
		execOpE             op;
		logic [`DATA_W-1:0] operand;     // Data, or effective address for stores
		logic [2:0]         shift;
		logic               fault;
	} execCmdT;

	// Bus wait counter, sized for the timeout
	typedef logic [$clog2(`BUS_TIMEOUT + 1)-1:0] waitCntT;

endpackage

// ==== src/stageReg.sv ====
module stageReg #(
	parameter type payloadT = logic [7:0]
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    inValid,
	output logic    inReady,
	input  payloadT inData,
	output logic    outValid,
	input  logic    outReady,
	output payloadT outData
);
	logic    skidValid;
	logic    skidValidNext;
	logic    outValidNext;
	logic    inFire;
	logic    outMove;
	payloadT skidData;

	assign inFire  = inValid && inReady;
	assign outMove = outReady || !outValid;     // Output slot frees this cycle

	always_comb begin
		skidValidNext = skidValid;
		outValidNext  = outValid;
		if (outMove) begin
			outValidNext  = skidValid || inFire;
			skidValidNext = 1'b0;
		end else if (inFire) begin
			skidValidNext = 1'b1;               // Output stalled, park in skid
		end
	end

	//////////////////////////////
	// Control
	always_ff @(posedge clk) begin
		if (rst) begin
			outValid  <= 1'b0;
			skidValid <= 1'b0;
			inReady   <= 1'b0;
		end else begin
			outValid  <= outValidNext;
			skidValid <= skidValidNext;
			inReady   <= !skidValidNext;        // Low only when both entries full
		end
	end

	//////////////////////////////
	// Data
	always_ff @(posedge clk) begin
		if (outMove) begin
			outData <= skidValid ? skidData : inData;
		end
		if (inFire && !outMove) begin
			skidData <= inData;
		end
	end

endmodule

// ==== src/instrDecoder.sv ====
`include "acc_params.svh"

module instrDecoder (
	input  accPkg::instrT    instr,
	output accPkg::execOpE   op,
	output accPkg::addrModeE mode,
	output logic             needsFetch,
	output logic             legal
);
	logic memForm;      // Opcode takes an addressing flag

	always_comb begin
		op      = accPkg::exAdd;
		mode    = accPkg::modeImm;
		legal   = 1'b1;
		memForm = 1'b1;

		case (instr.opcode)
			`OP_ADD:  op = accPkg::exAdd;
			`OP_SUB:  op = accPkg::exSub;
			`OP_OR:   op = accPkg::exOr;
			`OP_AND:  op = accPkg::exAnd;
			`OP_LOAD: op = accPkg::exLoad;
			`OP_STOR: op = accPkg::exStore;
			`OP_SHFT: begin
				memForm = 1'b0;                 // Count comes from the argument
				case (instr.flag)
					`FL_LS0: op = accPkg::exShl0;
					`FL_LS1: op = accPkg::exShl1;
					`FL_RS0: op = accPkg::exShr0;
					`FL_RS1: op = accPkg::exShr1;
					default: legal = 1'b0;
				endcase
			end
			`OP_NOP: begin
				memForm = 1'b0;
				legal   = 1'b0;
			end
			default: begin
				memForm = 1'b0;
				legal   = 1'b0;
			end
		endcase

		if (memForm) begin
			case (instr.flag)
				`FL_DIR: mode = accPkg::modeDir;
				`FL_IND: mode = accPkg::modeInd;
				`FL_IMM: legal = (op != accPkg::exStore);   // No immediate store
				default: legal = 1'b0;
			endcase
		end

		// Direct store already has its address
		needsFetch = legal && ((mode == accPkg::modeInd) ||
			((mode == accPkg::modeDir) && (op != accPkg::exStore)));
	end

endmodule

// ==== src/operandFetcher.sv ====
`include "acc_params.svh"

module operandFetcher (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  logic               indirect,
	input  logic               stopAtPointer,
	input  logic [`DATA_W-1:0] addr,
	output logic               done,
	output logic [`DATA_W-1:0] data,
	output logic               fault,
	output logic               wbCyc,
	output logic               wbStb,
	output logic [`DATA_W-1:0] wbAdr,
	input  logic [`DATA_W-1:0] wbDatIn,
	input  logic               wbAck
);
	typedef enum logic [1:0] {
		fIdle,
		fPtr,
		fGap,
		fOperand
	} fetchStateE;

	fetchStateE      state;
	accPkg::waitCntT waitCnt;
	logic            stopQ;
	logic            timedOut;
	logic            chainPtr;

	assign timedOut = (waitCnt == accPkg::waitCntT'(`BUS_TIMEOUT - 1));
	assign chainPtr = (state == fPtr) && !stopQ;    // Pointer feeds a second read
	assign wbStb    = wbCyc;

	//////////////////////////////
	// Bus sequencing
	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= fIdle;
			wbCyc   <= 1'b0;
			done    <= 1'b0;
			waitCnt <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				fIdle: begin
					if (start) begin
						wbCyc   <= 1'b1;
						waitCnt <= '0;
						state   <= indirect ? fPtr : fOperand;
					end
				end
				fGap: begin                 // Idle cycle between the two accesses
					wbCyc   <= 1'b1;
					waitCnt <= '0;
					state   <= fOperand;
				end
				fPtr, fOperand: begin
					if (wbAck) begin
						wbCyc <= 1'b0;
						if (chainPtr) begin
							state <= fGap;
						end else begin
							done  <= 1'b1;
							state <= fIdle;
						end
					end else if (timedOut) begin
						wbCyc <= 1'b0;          // Abandon, skip any second read
						done  <= 1'b1;
						state <= fIdle;
					end else begin
						waitCnt <= waitCnt + 1'b1;
					end
				end
				default: state <= fIdle;
			endcase
		end
	end

	//////////////////////////////
	// Address and result
	always_ff @(posedge clk) begin
		if ((state == fIdle) && start) begin
			wbAdr <= addr;
			stopQ <= stopAtPointer;
		end
		if (wbCyc && wbAck) begin
			if (chainPtr) begin
				wbAdr <= wbDatIn;
			end
			data  <= wbDatIn;
			fault <= 1'b0;
		end else if (wbCyc && timedOut) begin
			data  <= '0;
			fault <= 1'b1;
		end
	end

endmodule

// ==== src/sequencer.sv ====
`include "acc_params.svh"

module sequencer (
	input  logic               clk,
	input  logic               rst,
	input  logic               inValid,
	output logic               inReady,
	input  accPkg::instrT      inWord,
	output logic               fetchStart,
	output logic               fetchIndirect,
	output logic               fetchStopAtPointer,
	output logic [`DATA_W-1:0] fetchAddr,
	input  logic               fetchDone,
	input  logic [`DATA_W-1:0] fetchData,
	input  logic               fetchFault,
	output logic               cmdValid,
	input  logic               cmdReady,
	output accPkg::execCmdT    cmd
);
	typedef enum logic [1:0] {
		sIdle,
		sDecode,
		sFetch,
		sIssue
	} seqStateE;

	seqStateE         state;
	accPkg::instrT    instrQ;
	accPkg::execOpE   decOp;
	accPkg::addrModeE decMode;
	logic             decNeedsFetch;
	logic             decLegal;
	logic             isShift;

	instrDecoder decoder (
		.instr      (instrQ),
		.op         (decOp),
		.mode       (decMode),
		.needsFetch (decNeedsFetch),
		.legal      (decLegal)
	);

	assign inReady            = (state == sIdle);
	assign cmdValid           = (state == sIssue);
	assign fetchStart         = (state == sDecode) && decLegal && decNeedsFetch;
	assign fetchIndirect      = (decMode == accPkg::modeInd);
	assign fetchStopAtPointer = (decOp == accPkg::exStore);   // Result is the address
	assign fetchAddr          = instrQ.arg;
	assign isShift = decOp inside {accPkg::exShl0, accPkg::exShl1,
		accPkg::exShr0, accPkg::exShr1};

	//////////////////////////////
	// FSM
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sIdle;
		end else begin
			case (state)
				sIdle: begin
					if (inValid) begin
						state <= sDecode;
					end
				end
				sDecode: begin
					if (!decLegal) begin
						state <= sIdle;         // Dropped without a command
					end else if (decNeedsFetch) begin
						state <= sFetch;
					end else begin
						state <= sIssue;
					end
				end
				sFetch: begin
					if (fetchDone) begin
						state <= sIssue;
					end
				end
				sIssue: begin
					if (cmdReady) begin
						state <= sIdle;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	//////////////////////////////
	// Instruction and command
	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			instrQ <= inWord;
		end
		if (state == sDecode) begin
			cmd.op      <= decOp;
			cmd.operand <= instrQ.arg;      // Immediate, shift and direct store
			cmd.shift   <= isShift ? instrQ.arg[2:0] : 3'd0;
			cmd.fault   <= 1'b0;
		end
		if ((state == sFetch) && fetchDone) begin
			cmd.operand <= fetchData;
			cmd.fault   <= fetchFault;
		end
	end

endmodule

// ==== src/accCtrlTop.sv ====
`include "acc_params.svh"

module accCtrlTop (
	input  logic               clk,
	input  logic               rst,
	input  logic               instrValid,
	output logic               instrReady,
	input  accPkg::instrT      instrWord,
	output logic               wbCyc,
	output logic               wbStb,
	output logic [`DATA_W-1:0] wbAdr,
	input  logic [`DATA_W-1:0] wbDatIn,
	input  logic               wbAck,
	output logic               execValid,
	input  logic               execReady,
	output accPkg::execOpE     execOp,
	output logic [`DATA_W-1:0] execOperand,
	output logic [2:0]         execShift,
	output logic               execFault
);
	accPkg::instrT      seqWord;
	logic               seqValid;
	logic               seqReady;
	logic               fetchStart;
	logic               fetchIndirect;
	logic               fetchStop;
	logic [`DATA_W-1:0] fetchAddr;
	logic               fetchDone;
	logic [`DATA_W-1:0] fetchData;
	logic               fetchFault;
	accPkg::execCmdT    seqCmd;
	logic               cmdValid;
	logic               cmdReady;
	accPkg::execCmdT    outCmd;

	stageReg #(.payloadT(accPkg::instrT)) inStage (
		.clk (clk), .rst (rst),
		.inValid  (instrValid), .inReady  (instrReady), .inData  (instrWord),
		.outValid (seqValid),   .outReady (seqReady),   .outData (seqWord)
	);

	sequencer seq (
		.clk (clk), .rst (rst),
		.inValid (seqValid), .inReady (seqReady), .inWord (seqWord),
		.fetchStart (fetchStart), .fetchIndirect (fetchIndirect),
		.fetchStopAtPointer (fetchStop), .fetchAddr (fetchAddr),
		.fetchDone (fetchDone), .fetchData (fetchData), .fetchFault (fetchFault),
		.cmdValid (cmdValid), .cmdReady (cmdReady), .cmd (seqCmd)
	);

	operandFetcher fetcher (
		.clk (clk), .rst (rst),
		.start (fetchStart), .indirect (fetchIndirect), .stopAtPointer (fetchStop),
		.addr (fetchAddr), .done (fetchDone), .data (fetchData), .fault (fetchFault),
		.wbCyc (wbCyc), .wbStb (wbStb), .wbAdr (wbAdr),
		.wbDatIn (wbDatIn), .wbAck (wbAck)
	);

	stageReg #(.payloadT(accPkg::execCmdT)) outStage (
		.clk (clk), .rst (rst),
		.inValid  (cmdValid),  .inReady  (cmdReady),  .inData  (seqCmd),
		.outValid (execValid), .outReady (execReady), .outData (outCmd)
	);

	assign execOp      = outCmd.op;
	assign execOperand = outCmd.operand;
	assign execShift   = outCmd.shift;
	assign execFault   = outCmd.fault;

endmodule

// ==== tb/wbMemModel.sv ====
`include "acc_params.svh"

module wbMemModel (
	input  logic               clk,
	input  logic               rst,
	input  logic               wbCyc,
	input  logic               wbStb,
	input  logic [`DATA_W-1:0] wbAdr,
	output logic [`DATA_W-1:0] wbDat,
	output logic               wbAck
);
	logic [1:0] delayCnt;
	logic       deadRegion;

	assign deadRegion = (wbAdr[`DATA_W-1 -: 4] == 4'hF);   // Top nibble F never acks
	assign wbDat      = wbAdr ^ 8'h5A;

	//////////////////////////////
	// Ack after addr[1:0] extra cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			wbAck    <= 1'b0;
			delayCnt <= 2'd0;
		end else if (!(wbCyc && wbStb) || wbAck) begin
			wbAck    <= 1'b0;                    // One-cycle ack
			delayCnt <= 2'd0;
		end else if (!deadRegion && (delayCnt == wbAdr[1:0])) begin
			wbAck <= 1'b1;
		end else begin
			delayCnt <= delayCnt + 2'd1;
		end
	end

endmodule

// ==== tb/accCtrl_asserts.sv ====
`include "acc_params.svh"

module accCtrl_asserts (
	input logic               clk,
	input logic               rst,
	input logic               wbCyc,
	input logic               wbStb,
	input logic [`DATA_W-1:0] wbAdr,
	input logic               wbAck,
	input logic               execValid,
	input logic               execReady,
	input accPkg::execOpE     execOp,
	input logic [`DATA_W-1:0] execOperand,
	input logic [2:0]         execShift,
	input logic               execFault
);
	int failures = 0;       // Assertion failures so far

	stbFollowsCyc: assert property (@(posedge clk) disable iff (rst) wbStb == wbCyc)
		else begin
			$error("wbStb differs from wbCyc");
			failures++;
		end

	adrStable: assert property (@(posedge clk) disable iff (rst)
		(wbCyc && !wbAck) |=> (!wbCyc || $stable(wbAdr)))
		else begin
			$error("wbAdr changed during an open bus cycle");
			failures++;
		end

	cycBounded: assert property (@(posedge clk) disable iff (rst)
		(wbCyc && !wbAck) [*`BUS_TIMEOUT] |=> !wbCyc)
		else begin
			$error("wbCyc held past the bus timeout without ack");
			failures++;
		end

	idleAfterReset: assert property (@(posedge clk) $fell(rst) |-> (!execValid && !wbCyc))
		else begin
			$error("execValid or wbCyc high right after reset");
			failures++;
		end

	execHeld: assert property (@(posedge clk) disable iff (rst)
		(execValid && !execReady) |=> (execValid && $stable(execOp) &&
		$stable(execOperand) && $stable(execShift) && $stable(execFault)))
		else begin
			$error("Execute command dropped or changed before acceptance");
			failures++;
		end

endmodule

bind accCtrlTop accCtrl_asserts chk (
	.clk (clk), .rst (rst),
	.wbCyc (wbCyc), .wbStb (wbStb), .wbAdr (wbAdr), .wbAck (wbAck),
	.execValid (execValid), .execReady (execReady), .execOp (execOp),
	.execOperand (execOperand), .execShift (execShift), .execFault (execFault)
);

// ==== tb/accCtrl_tb.sv ====
`include "acc_params.svh"

module accCtrl_tb;
	localparam logic [31:0] SEED        = 32'h1937e7e9;
	localparam int          NUM_INSTR   = 400;
	localparam int          WAIT_LIMIT  = 300;
	localparam int          DRAIN_LIMIT = 600;

	logic               clk;
	logic               rst;
	logic               instrValid;
	logic               instrReady;
	accPkg::instrT      instrWord;
	logic               wbCyc;
	logic               wbStb;
	logic [`DATA_W-1:0] wbAdr;
	logic [`DATA_W-1:0] wbDat;
	logic               wbAck;
	logic               execValid;
	logic               execReady;
	accPkg::execOpE     execOp;
	logic [`DATA_W-1:0] execOperand;
	logic [2:0]         execShift;
	logic               execFault;

	accPkg::execCmdT expected[$];       // Commands still owed by the DUT
	logic [31:0]     stimState;
	logic [31:0]     readyState;
	int              errors;
	int              checks;
	int              sent;
	int              received;
	int              lowLeft;
	logic            aborted;
	logic            heldValid;
	logic [15:0]     heldBits;

	accCtrlTop uut (
		.clk (clk), .rst (rst),
		.instrValid (instrValid), .instrReady (instrReady), .instrWord (instrWord),
		.wbCyc (wbCyc), .wbStb (wbStb), .wbAdr (wbAdr), .wbDatIn (wbDat), .wbAck (wbAck),
		.execValid (execValid), .execReady (execReady), .execOp (execOp),
		.execOperand (execOperand), .execShift (execShift), .execFault (execFault)
	);

	wbMemModel mem (
		.clk (clk), .rst (rst),
		.wbCyc (wbCyc), .wbStb (wbStb), .wbAdr (wbAdr), .wbDat (wbDat), .wbAck (wbAck)
	);

	always #4 clk = ~clk;

	function automatic int unsigned randomBelow(inout logic [31:0] state,
		input int unsigned range);
		state = state * 32'd1664525 + 32'd1013904223;   // LCG step
		return state[31:16] % range;
	endfunction

	function automatic logic [`DATA_W-1:0] memValue(input logic [`DATA_W-1:0] addr);
		return addr ^ 8'h5A;
	endfunction

	function automatic logic neverAcked(input logic [`DATA_W-1:0] addr);
		return addr[`DATA_W-1 -: 4] == 4'hF;
	endfunction

	function automatic accPkg::instrT randomInstr();
		accPkg::instrT w;
		case (randomBelow(stimState, 10))
			0: w.opcode = `OP_ADD;
			1: w.opcode = `OP_SUB;
			2: w.opcode = `OP_OR;
			3: w.opcode = `OP_AND;
			4: w.opcode = `OP_SHFT;
			5: w.opcode = `OP_LOAD;
			6: w.opcode = `OP_STOR;
			7: w.opcode = `OP_NOP;
			default: w.opcode = 5'(randomBelow(stimState, 32));
		endcase
		if (randomBelow(stimState, 4) == 0) begin
			w.flag = 3'(randomBelow(stimState, 8));     // Often unsupported
		end else if (w.opcode == `OP_SHFT) begin
			w.flag = 3'(randomBelow(stimState, 4));     // LS0 to RS1
		end else begin
			case (randomBelow(stimState, 3))
				0: w.flag = `FL_DIR;
				1: w.flag = `FL_IND;
				default: w.flag = `FL_IMM;
			endcase
		end
		w.arg = 8'(randomBelow(stimState, 256));
		return w;
	endfunction

	// Returns 0 when the instruction yields no command
	function automatic logic predictCmd(input accPkg::instrT w, output accPkg::execCmdT c);
		logic [`DATA_W-1:0] addr;
		c.op      = accPkg::exAdd;
		c.operand = w.arg;
		c.shift   = 3'd0;
		c.fault   = 1'b0;
		case (w.opcode)
			`OP_ADD:  c.op = accPkg::exAdd;
			`OP_SUB:  c.op = accPkg::exSub;
			`OP_OR:   c.op = accPkg::exOr;
			`OP_AND:  c.op = accPkg::exAnd;
			`OP_LOAD: c.op = accPkg::exLoad;
			`OP_STOR: c.op = accPkg::exStore;
			`OP_SHFT: begin
				case (w.flag)
					`FL_LS0: c.op = accPkg::exShl0;
					`FL_LS1: c.op = accPkg::exShl1;
					`FL_RS0: c.op = accPkg::exShr0;
					`FL_RS1: c.op = accPkg::exShr1;
					default: return 1'b0;
				endcase
				c.shift = w.arg[2:0];
				return 1'b1;
			end
			default: return 1'b0;           // NOP and unknown codes
		endcase
		if (w.flag == `FL_IMM) begin
			return c.op != accPkg::exStore;
		end
		if ((w.flag != `FL_DIR) && (w.flag != `FL_IND)) begin
			return 1'b0;
		end
		addr = w.arg;
		if (w.flag == `FL_IND) begin
			if (neverAcked(addr)) begin     // Pointer read times out
				c.operand = '0;
				c.fault   = 1'b1;
				return 1'b1;
			end
			addr = memValue(addr);
		end
		if (c.op == accPkg::exStore) begin
			c.operand = addr;               // Effective address
		end else if (neverAcked(addr)) begin
			c.operand = '0;
			c.fault   = 1'b1;
		end else begin
			c.operand = memValue(addr);
		end
		return 1'b1;
	endfunction

	task automatic checkField(input string field, input logic [15:0] got,
		input logic [15:0] want);
		checks++;
		assert (got == want) else begin
			errors++;
			$display("ERR %0t: command %0d %s is %0h, expected %0h", $time, received,
				field, got, want);
		end
	endtask

	//////////////////////////////
	// Execute back-pressure
	always @(posedge clk) begin
		if (lowLeft != 0) begin
			execReady <= 1'b0;
			lowLeft   <= lowLeft - 1;
		end else if (randomBelow(readyState, 5) == 0) begin
			execReady <= 1'b0;
			lowLeft   <= randomBelow(readyState, 12);
		end else begin
			execReady <= 1'b1;
		end
	end

	//////////////////////////////
	// Output monitor
	always @(posedge clk) begin
		accPkg::execCmdT want;
		if (rst) begin
			heldValid = 1'b0;
		end else begin
			if (heldValid) begin
				checks++;
				assert (execValid && ({execOp, execOperand, execShift, execFault} == heldBits))
				else begin
					errors++;
					$display("ERR %0t: stalled command changed before acceptance", $time);
				end
			end
			heldValid = execValid && !execReady;
			heldBits  = {execOp, execOperand, execShift, execFault};
			if (execValid && execReady) begin
				received++;
				checks++;
				assert (expected.size() != 0) else begin
					errors++;
					$display("Extra command at time %0t with no instruction to match", $time);
				end
				if (expected.size() != 0) begin
					want = expected.pop_front();
					checkField("op", 16'(execOp), 16'(want.op));
					checkField("operand", 16'(execOperand), 16'(want.operand));
					checkField("shift", 16'(execShift), 16'(want.shift));
					checkField("fault", 16'(execFault), 16'(want.fault));
				end
			end
		end
	end

	//////////////////////////////
	// Stimulus
	initial begin
		accPkg::instrT   w;
		accPkg::execCmdT c;
		int              gap;
		int              waitCnt;
		clk        = 1'b0;
		rst        = 1'b1;
		instrValid = 1'b0;
		instrWord  = '0;
		execReady  = 1'b0;
		stimState  = SEED;
		readyState = ~SEED;         // Separate stream for execReady
		errors     = 0;
		checks     = 0;
		sent       = 0;
		received   = 0;
		lowLeft    = 0;
		aborted    = 1'b0;
		heldValid  = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; (i < NUM_INSTR) && !aborted; i++) begin
			gap = (randomBelow(stimState, 4) == 0) ? randomBelow(stimState, 3) + 1 : 0;
			if (gap != 0) begin
				instrValid <= 1'b0;
				repeat (gap) @(posedge clk);
			end
			w = randomInstr();
			instrValid <= 1'b1;
			instrWord  <= w;
			waitCnt = 0;
			do begin
				@(posedge clk);
				waitCnt++;
			end while (!instrReady && (waitCnt < WAIT_LIMIT));
			if (!instrReady) begin
				$display("Timeout: instruction %0d was never accepted", i);
				errors++;
				aborted = 1'b1;
			end else begin
				sent++;
				if (predictCmd(w, c)) begin
					expected.push_back(c);
				end
			end
		end
		instrValid <= 1'b0;

		if (!aborted) begin
			waitCnt = 0;
			while ((expected.size() != 0) && (waitCnt < DRAIN_LIMIT)) begin
				@(posedge clk);
				waitCnt++;
			end
			repeat (40) @(posedge clk);     // Catch any extra command
			checks++;
			assert (expected.size() == 0) else begin
				errors++;
				$display("Timeout: %0d expected commands never arrived", expected.size());
			end
		end

		$display("sent %0d  received %0d  checks %0d  errors %0d  assertion failures %0d",
			sent, received, checks, errors, uut.chk.failures);
		if ((errors == 0) && (uut.chk.failures == 0)) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+src
src/accPkg.sv
src/stageReg.sv
src/instrDecoder.sv
src/operandFetcher.sv
src/sequencer.sv
src/accCtrlTop.sv
tb/wbMemModel.sv
tb/accCtrl_asserts.sv
tb/accCtrl_tb.sv

// ==== Bender.yml ====
package:
  name: acc_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/accPkg.sv
      - src/stageReg.sv
      - src/instrDecoder.sv
      - src/operandFetcher.sv
      - src/sequencer.sv
      - src/accCtrlTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/wbMemModel.sv
      - tb/accCtrl_asserts.sv
      - tb/accCtrl_tb.sv
